/* tmu_consts.svh */
// texture cache sizing.
// 16-bit texel addresses, 16 lines of 32 bytes.
`ifndef TMU_CONSTS_SVH
`define TMU_CONSTS_SVH

// texel byte address.
`define TMU_ADDR_W 16
`define TMU_DADR_W (`TMU_ADDR_W - 1)
// log2 of the cache size in bytes.
`define TMU_CACHE_DEPTH 9
`define TMU_LINE_W 5
`define TMU_FRAC_W 6

`endif

/* tmu_addr_pkg.sv */
// texel address layout.
// one word, read flat or as tag, line index and byte offset.
`include "tmu_consts.svh"

package tmu_addr_pkg;

	localparam int TAG_W = `TMU_ADDR_W - `TMU_CACHE_DEPTH; // 7 bits.
	localparam int IDX_W = `TMU_CACHE_DEPTH - `TMU_LINE_W; // 16 lines.

	// tag in the top bits, offset at the bottom.
	typedef union packed {
		logic [`TMU_ADDR_W-1:0] flat;
		struct packed {
			logic [TAG_W-1:0] tag;
			logic [IDX_W-1:0] idx;
			logic [`TMU_LINE_W-1:0] ofs;
		} f;
	} texel_addr_u;

endpackage

/* tmu_ctl_pkg.sv */
// control states of the texel cache front end.
// tag stage and miss fetch stage.

package tmu_ctl_pkg;

	typedef enum logic [1:0] {
		running,
		resolve_miss, // one extra tag rewrite per cycle.
		flushing
	} tag_state_e;

	typedef enum logic [1:0] {
		idle,
		fetching,
		forwarding
	} fetch_state_e;

endpackage

/* tmu_dpram.sv */
`timescale 1ns/1ns
// tag RAM copy.
// registered read with enable, synchronous write.

module tmu_dpram #(
	parameter int depth = 4, // address bits.
	parameter int width = 8
) (
	input  logic             sys_clk,

	input  logic [depth-1:0] ra_i,
	input  logic             re_i,
	output logic [width-1:0] rd_o,

	input  logic [depth-1:0] wa_i,
	input  logic             we_i,
	input  logic [width-1:0] wd_i
);

	logic [width-1:0] mem [0:(1<<depth)-1];

	always_ff @(posedge sys_clk) begin
		if (we_i)
			mem[wa_i] <= wd_i;
		if (re_i) begin
			// a tag written this cycle is seen by the read.
			if (we_i && (wa_i == ra_i))
				rd_o <= wd_i;
			else
				rd_o <= mem[ra_i];
		end
	end

endmodule

/* tmu_tagmem.sv */
`timescale 1ns/1ns
// texel cache tag stage.
// elects one leader per line group, checks four tag copies,
// rewrites the tags of missing lines and walks the lines on a flush.
`include "tmu_consts.svh"

module tmu_tagmem (
	input  logic                       sys_clk,
	input  logic                       sys_rst,

	input  logic                       flush_i,
	output logic                       busy_o,

	input  logic                       pipe_stb_i,
	output logic                       pipe_ack_o,
	input  logic [`TMU_DADR_W-1:0]     dadr_i,
	input  tmu_addr_pkg::texel_addr_u  tadra_i,
	input  tmu_addr_pkg::texel_addr_u  tadrb_i,
	input  tmu_addr_pkg::texel_addr_u  tadrc_i,
	input  tmu_addr_pkg::texel_addr_u  tadrd_i,
	input  logic [`TMU_FRAC_W-1:0]     x_frac_i,
	input  logic [`TMU_FRAC_W-1:0]     y_frac_i,

	output logic                       pipe_stb_o,
	input  logic                       pipe_ack_i,
	output logic [`TMU_DADR_W-1:0]     dadr_o,
	output tmu_addr_pkg::texel_addr_u  tadra_o,
	output tmu_addr_pkg::texel_addr_u  tadrb_o,
	output tmu_addr_pkg::texel_addr_u  tadrc_o,
	output tmu_addr_pkg::texel_addr_u  tadrd_o,
	output logic [`TMU_FRAC_W-1:0]     x_frac_o,
	output logic [`TMU_FRAC_W-1:0]     y_frac_o,
	output logic                       miss_a_o,
	output logic                       miss_b_o,
	output logic                       miss_c_o,
	output logic                       miss_d_o
);

	import tmu_addr_pkg::*;
	import tmu_ctl_pkg::*;

	localparam int WORD_W = TAG_W + 1; // {valid, tag}.

	tag_state_e state, next_state;
	texel_addr_u tadr_in [4];
	texel_addr_u tadr_r [4];
	logic [IDX_W-1:0] ci [4];
	logic [WORD_W-1:0] tag_rd [4];
	logic valid_b, valid_c, valid_d;
	logic [3:0] lead, lead_r, miss, cand, rest, missmask;
	logic multi_miss, req_valid, tag_re, tag_we, mask_we;
	logic [1:0] tag_sel;
	logic [IDX_W-1:0] tag_wa, flush_cnt;
	logic [WORD_W-1:0] tag_wd;

	assign tadr_in[0] = tadra_i;
	assign tadr_in[1] = tadrb_i;
	assign tadr_in[2] = tadrc_i;
	assign tadr_in[3] = tadrd_i;

	// ====================
	// leader election
	// ====================
	assign valid_b = x_frac_i != '0; // b and d only count with a fraction.
	assign valid_c = y_frac_i != '0;
	assign valid_d = valid_b & valid_c;

	// the last valid channel of a group leads it.
	assign lead[0] = ~(valid_b & (ci[0] == ci[1])) & ~(valid_c & (ci[0] == ci[2]))
		& ~(valid_d & (ci[0] == ci[3]));
	assign lead[1] = valid_b & ~(valid_c & (ci[1] == ci[2])) & ~(valid_d & (ci[1] == ci[3]));
	assign lead[2] = valid_c & ~(valid_d & (ci[2] == ci[3]));
	assign lead[3] = valid_d;

	// ====================
	// tag copies and misses
	// ====================
	for (genvar g = 0; g < 4; g++) begin : g_chan
		assign ci[g] = tadr_in[g].f.idx;

		tmu_dpram #(
			.depth(IDX_W),
			.width(WORD_W)
		) u_tag (
			.sys_clk(sys_clk),
			.ra_i(ci[g]),
			.re_i(tag_re),
			.rd_o(tag_rd[g]),
			.wa_i(tag_wa),
			.we_i(tag_we),
			.wd_i(tag_wd)
		);

		assign miss[g] = lead_r[g]
			& (~tag_rd[g][TAG_W] | (tag_rd[g][TAG_W-1:0] != tadr_r[g].f.tag));
	end

	assign multi_miss = (miss & (miss - 4'd1)) != 4'd0;

	// misses still to be written, lowest first.
	assign cand = (state == resolve_miss) ? missmask : miss;
	assign rest = cand & (cand - 4'd1);

	always_comb begin
		tag_sel = 2'd3;
		for (int i = 3; i >= 0; i--) begin
			if (cand[i])
				tag_sel = 2'(i);
		end
	end

	always_comb begin
		if (state == flushing) begin
			tag_wa = flush_cnt;
			tag_wd = '0; // line invalid.
		end else begin
			tag_wa = tadr_r[tag_sel].f.idx;
			tag_wd = {1'b1, tadr_r[tag_sel].f.tag};
		end
	end

	// ====================
	// control
	// ====================
	always_comb begin
		next_state = state;
		tag_re = 1'b0;
		tag_we = 1'b0;
		mask_we = 1'b0;
		pipe_stb_o = 1'b0;
		case (state)
			running: begin
				if (req_valid) begin
					pipe_stb_o = 1'b1;
					if (pipe_ack_i) begin
						tag_we = |miss; // first miss rides along.
						mask_we = 1'b1;
						if (multi_miss)
							next_state = resolve_miss;
						else
							tag_re = 1'b1;
					end
				end else if (flush_i)
					next_state = flushing;
				else
					tag_re = 1'b1;
			end
			resolve_miss: begin
				tag_we = 1'b1;
				mask_we = 1'b1;
				if (rest == 4'd0) begin
					tag_re = 1'b1;
					next_state = running;
				end
			end
			flushing: begin
				tag_we = 1'b1;
				if (flush_cnt == '1)
					next_state = running;
			end
			default: next_state = running;
		endcase
	end

	assign pipe_ack_o = tag_re;
	assign busy_o = (state != running) | req_valid;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= running;
			req_valid <= 1'b0;
			missmask <= '0;
			flush_cnt <= '0;
		end else begin
			state <= next_state;
			if (tag_re)
				req_valid <= pipe_stb_i;
			if (mask_we)
				missmask <= rest;
			if (state == flushing)
				flush_cnt <= flush_cnt + 1'b1; // wraps back to 0.
		end
	end

	// forward register, loaded with the tag read.
	always_ff @(posedge sys_clk) begin
		if (tag_re) begin
			lead_r <= lead;
			tadr_r <= tadr_in;
			dadr_o <= dadr_i;
			x_frac_o <= x_frac_i;
			y_frac_o <= y_frac_i;
		end
	end

	assign tadra_o = tadr_r[0];
	assign tadrb_o = tadr_r[1];
	assign tadrc_o = tadr_r[2];
	assign tadrd_o = tadr_r[3];
	assign miss_a_o = miss[0];
	assign miss_b_o = miss[1];
	assign miss_c_o = miss[2];
	assign miss_d_o = miss[3];

endmodule

/* tmu_miss_fetch.sv */
`timescale 1ns/1ns
// miss fetch stage.
// issues one line fetch per missing channel, a to d, then offers the fragment.
`include "tmu_consts.svh"

module tmu_miss_fetch (
	input  logic                       sys_clk,
	input  logic                       sys_rst,

	input  logic                       tag_stb_i,
	output logic                       tag_ack_o,
	input  logic [`TMU_DADR_W-1:0]     dadr_i,
	input  tmu_addr_pkg::texel_addr_u  tadra_i,
	input  tmu_addr_pkg::texel_addr_u  tadrb_i,
	input  tmu_addr_pkg::texel_addr_u  tadrc_i,
	input  tmu_addr_pkg::texel_addr_u  tadrd_i,
	input  logic [`TMU_FRAC_W-1:0]     x_frac_i,
	input  logic [`TMU_FRAC_W-1:0]     y_frac_i,
	input  logic                       miss_a_i,
	input  logic                       miss_b_i,
	input  logic                       miss_c_i,
	input  logic                       miss_d_i,

	output logic                       fetch_stb_o,
	output tmu_addr_pkg::texel_addr_u  fetch_adr_o,
	input  logic                       fetch_ack_i,

	output logic                       frag_stb_o,
	output logic [`TMU_DADR_W-1:0]     frag_dadr_o,
	output tmu_addr_pkg::texel_addr_u  frag_tadra_o,
	output tmu_addr_pkg::texel_addr_u  frag_tadrb_o,
	output tmu_addr_pkg::texel_addr_u  frag_tadrc_o,
	output tmu_addr_pkg::texel_addr_u  frag_tadrd_o,
	output logic [`TMU_FRAC_W-1:0]     frag_x_frac_o,
	output logic [`TMU_FRAC_W-1:0]     frag_y_frac_o,
	output logic [3:0]                 frag_miss_o,
	input  logic                       frag_ack_i
);

	import tmu_addr_pkg::*;
	import tmu_ctl_pkg::*;

	fetch_state_e state, next_state;
	logic [3:0] miss_in, pending;
	texel_addr_u line_adr;

	assign miss_in = {miss_d_i, miss_c_i, miss_b_i, miss_a_i};

	assign tag_ack_o = (state == idle) & tag_stb_i; // single cycle, idle only.
	assign fetch_stb_o = state == fetching;
	assign frag_stb_o = state == forwarding;

	// line of the lowest pending channel.
	always_comb begin
		if (pending[0])
			line_adr = frag_tadra_o;
		else if (pending[1])
			line_adr = frag_tadrb_o;
		else if (pending[2])
			line_adr = frag_tadrc_o;
		else
			line_adr = frag_tadrd_o;
		line_adr.f.ofs = '0;
	end

	assign fetch_adr_o = line_adr;

	always_comb begin
		next_state = state;
		case (state)
			idle:
				if (tag_stb_i)
					next_state = (miss_in != 4'd0) ? fetching : forwarding;
			fetching:
				if (fetch_ack_i && ((pending & (pending - 4'd1)) == 4'd0))
					next_state = forwarding; // last line requested.
			forwarding:
				if (frag_ack_i)
					next_state = idle;
			default: next_state = idle;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= idle;
			pending <= '0;
		end else begin
			state <= next_state;
			if (tag_ack_o)
				pending <= miss_in;
			else if (fetch_stb_o && fetch_ack_i)
				pending <= pending & (pending - 4'd1); // drop lowest.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (tag_ack_o) begin
			frag_dadr_o <= dadr_i;
			frag_tadra_o <= tadra_i;
			frag_tadrb_o <= tadrb_i;
			frag_tadrc_o <= tadrc_i;
			frag_tadrd_o <= tadrd_i;
			frag_x_frac_o <= x_frac_i;
			frag_y_frac_o <= y_frac_i;
			frag_miss_o <= miss_in; // kept as it came.
		end
	end

endmodule

/* tmu_texcache.sv */
`timescale 1ns/1ns
// texel cache front end.
// tag stage followed by the miss fetch stage.
`include "tmu_consts.svh"

module tmu_texcache (
	input  logic                       sys_clk,
	input  logic                       sys_rst,

	input  logic                       flush_i,
	output logic                       busy_o,

	input  logic                       pipe_stb_i,
	output logic                       pipe_ack_o,
	input  logic [`TMU_DADR_W-1:0]     dadr_i,
	input  tmu_addr_pkg::texel_addr_u  tadra_i,
	input  tmu_addr_pkg::texel_addr_u  tadrb_i,
	input  tmu_addr_pkg::texel_addr_u  tadrc_i,
	input  tmu_addr_pkg::texel_addr_u  tadrd_i,
	input  logic [`TMU_FRAC_W-1:0]     x_frac_i,
	input  logic [`TMU_FRAC_W-1:0]     y_frac_i,

	output logic                       fetch_stb_o,
	output tmu_addr_pkg::texel_addr_u  fetch_adr_o,
	input  logic                       fetch_ack_i,

	output logic                       frag_stb_o,
	output logic [`TMU_DADR_W-1:0]     frag_dadr_o,
	output tmu_addr_pkg::texel_addr_u  frag_tadra_o,
	output tmu_addr_pkg::texel_addr_u  frag_tadrb_o,
	output tmu_addr_pkg::texel_addr_u  frag_tadrc_o,
	output tmu_addr_pkg::texel_addr_u  frag_tadrd_o,
	output logic [`TMU_FRAC_W-1:0]     frag_x_frac_o,
	output logic [`TMU_FRAC_W-1:0]     frag_y_frac_o,
	output logic [3:0]                 frag_miss_o,
	input  logic                       frag_ack_i
);

	import tmu_addr_pkg::*;

	// tag stage to fetch stage.
	logic tag_stb, tag_ack;
	logic [`TMU_DADR_W-1:0] tag_dadr;
	texel_addr_u tag_tadra, tag_tadrb, tag_tadrc, tag_tadrd;
	logic [`TMU_FRAC_W-1:0] tag_x_frac, tag_y_frac;
	logic tag_miss_a, tag_miss_b, tag_miss_c, tag_miss_d;

	tmu_tagmem u_tagmem (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush_i),
		.busy_o(busy_o),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.dadr_i(dadr_i),
		.tadra_i(tadra_i),
		.tadrb_i(tadrb_i),
		.tadrc_i(tadrc_i),
		.tadrd_i(tadrd_i),
		.x_frac_i(x_frac_i),
		.y_frac_i(y_frac_i),
		.pipe_stb_o(tag_stb),
		.pipe_ack_i(tag_ack),
		.dadr_o(tag_dadr),
		.tadra_o(tag_tadra),
		.tadrb_o(tag_tadrb),
		.tadrc_o(tag_tadrc),
		.tadrd_o(tag_tadrd),
		.x_frac_o(tag_x_frac),
		.y_frac_o(tag_y_frac),
		.miss_a_o(tag_miss_a),
		.miss_b_o(tag_miss_b),
		.miss_c_o(tag_miss_c),
		.miss_d_o(tag_miss_d)
	);

	tmu_miss_fetch u_fetch (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.tag_stb_i(tag_stb),
		.tag_ack_o(tag_ack),
		.dadr_i(tag_dadr),
		.tadra_i(tag_tadra),
		.tadrb_i(tag_tadrb),
		.tadrc_i(tag_tadrc),
		.tadrd_i(tag_tadrd),
		.x_frac_i(tag_x_frac),
		.y_frac_i(tag_y_frac),
		.miss_a_i(tag_miss_a),
		.miss_b_i(tag_miss_b),
		.miss_c_i(tag_miss_c),
		.miss_d_i(tag_miss_d),
		.fetch_stb_o(fetch_stb_o),
		.fetch_adr_o(fetch_adr_o),
		.fetch_ack_i(fetch_ack_i),
		.frag_stb_o(frag_stb_o),
		.frag_dadr_o(frag_dadr_o),
		.frag_tadra_o(frag_tadra_o),
		.frag_tadrb_o(frag_tadrb_o),
		.frag_tadrc_o(frag_tadrc_o),
		.frag_tadrd_o(frag_tadrd_o),
		.frag_x_frac_o(frag_x_frac_o),
		.frag_y_frac_o(frag_y_frac_o),
		.frag_miss_o(frag_miss_o),
		.frag_ack_i(frag_ack_i)
	);

endmodule

/* tb_checker.sv */
`timescale 1ns/1ns
// testbench checker for the texel cache front end.
// compares fetch requests and fragment outputs with queued expectations
// and times the flush walk, one result line per test.
`include "tmu_consts.svh"

module tb_checker #(
	parameter int FRAG_W = `TMU_DADR_W + 4 * `TMU_ADDR_W + 2 * `TMU_FRAC_W
) (
	input  logic                   sys_clk,
	input  logic                   sys_rst,
	input  logic                   flush_i,
	input  logic                   busy_i,
	input  logic                   pipe_ack_i,
	input  logic                   fetch_stb_i,
	input  logic                   fetch_ack_i,
	input  logic [`TMU_ADDR_W-1:0] fetch_adr_i,
	input  logic                   frag_stb_i,
	input  logic                   frag_ack_i,
	input  logic [FRAG_W-1:0]      frag_word_i,
	input  logic [3:0]             frag_miss_i,
	output int                     n_pass_o,
	output int                     n_fail_o,
	output int                     n_err_o,
	output int                     n_open_o
);

	localparam int WALK_CYCLES = 1 << (`TMU_CACHE_DEPTH - `TMU_LINE_W); // one per line.

	// one entry per outstanding fragment, oldest first.
	string name_q [$];
	logic [FRAG_W-1:0] word_q [$];
	logic [3:0] miss_q [$];
	int nfetch_q [$];
	logic [`TMU_ADDR_W-1:0] fetch_q [$]; // all expected line addresses, in order.

	int seen_fetch = 0; // fetches seen for the oldest fragment.
	logic test_bad = 1'b0;
	logic in_walk = 1'b0;
	int walk_len = 0;
	int walk_acks = 0;
	int n_pass = 0;
	int n_fail = 0;
	int n_err = 0;
	int n_open = 0;

	assign n_pass_o = n_pass;
	assign n_fail_o = n_fail;
	assign n_err_o = n_err;
	assign n_open_o = n_open;

	task automatic add_expectation(input string name, input logic [FRAG_W-1:0] word,
		input logic [3:0] miss, input logic [`TMU_ADDR_W-1:0] f0,
		input logic [`TMU_ADDR_W-1:0] f1, input logic [`TMU_ADDR_W-1:0] f2,
		input logic [`TMU_ADDR_W-1:0] f3);
		logic [`TMU_ADDR_W-1:0] fa [4];
		int n;
		fa[0] = f0;
		fa[1] = f1;
		fa[2] = f2;
		fa[3] = f3;
		n = $countones(miss); // one fetch per missing channel.
		name_q.push_back(name);
		word_q.push_back(word);
		miss_q.push_back(miss);
		nfetch_q.push_back(n);
		for (int i = 0; i < n; i++)
			fetch_q.push_back(fa[i]);
		n_open++;
	endtask

	// ====================
	// fetch requests
	// ====================
	task automatic check_fetch();
		logic [`TMU_ADDR_W-1:0] exp;
		if (name_q.size() == 0) begin
			$display("error: fetch of %h while no fragment is outstanding", fetch_adr_i);
			n_err++;
		end else if (seen_fetch >= nfetch_q[0]) begin
			$display("error: test %s issued more fetches than it has misses (%h)",
				name_q[0], fetch_adr_i);
			n_err++;
			test_bad = 1'b1;
		end else begin
			exp = fetch_q.pop_front();
			if (fetch_adr_i !== exp) begin
				$display("CHECK FAILED %s fetch %0d expected %h actual %h",
					name_q[0], seen_fetch, exp, fetch_adr_i);
				n_err++;
				test_bad = 1'b1;
			end
			seen_fetch++;
		end
	endtask

	// ====================
	// fragment outputs
	// ====================
	task automatic check_frag();
		string name;
		logic [FRAG_W-1:0] exp_word;
		logic [3:0] exp_miss;
		int exp_n;
		logic [`TMU_ADDR_W-1:0] drop;
		if (name_q.size() == 0) begin
			$display("error: fragment output while no fragment is outstanding");
			n_err++;
		end else begin
			name = name_q.pop_front();
			exp_word = word_q.pop_front();
			exp_miss = miss_q.pop_front();
			exp_n = nfetch_q.pop_front();
			if (seen_fetch < exp_n) begin
				$display("CHECK FAILED %s fetch count expected %0d actual %0d",
					name, exp_n, seen_fetch);
				n_err++;
				test_bad = 1'b1;
				for (int i = seen_fetch; i < exp_n; i++)
					drop = fetch_q.pop_front(); // skip the missing ones.
			end
			if (frag_miss_i !== exp_miss) begin
				$display("CHECK FAILED %s miss mask expected %h actual %h",
					name, exp_miss, frag_miss_i);
				n_err++;
				test_bad = 1'b1;
			end
			if (frag_word_i !== exp_word) begin
				$display("CHECK FAILED %s fields expected %h actual %h",
					name, exp_word, frag_word_i);
				n_err++;
				test_bad = 1'b1;
			end
			if (test_bad) begin
				n_fail++;
				$display("test %s: failed", name);
			end else begin
				n_pass++;
				$display("test %s: passed", name);
			end
			test_bad = 1'b0;
			seen_fetch = 0;
			n_open--;
		end
	endtask

	// transfers complete on a rising edge with stb and ack high.
	always @(posedge sys_clk) begin
		if (!sys_rst && fetch_stb_i && fetch_ack_i)
			check_fetch();
		if (!sys_rst && frag_stb_i && frag_ack_i)
			check_frag();
	end

	// ====================
	// flush walk
	// ====================
	task automatic finish_walk();
		logic bad;
		bad = 1'b0;
		if (walk_len != WALK_CYCLES) begin
			$display("CHECK FAILED flush busy cycles expected %0d actual %0d",
				WALK_CYCLES, walk_len);
			n_err++;
			bad = 1'b1;
		end
		if (walk_acks != 0) begin
			$display("error: pipe_ack_o was high in %0d cycles of the flush walk",
				walk_acks);
			n_err++;
			bad = 1'b1;
		end
		if (bad) begin
			n_fail++;
			$display("test flush: failed");
		end else begin
			n_pass++;
			$display("test flush: passed");
		end
		in_walk = 1'b0;
	endtask

	// the walk starts after the edge that samples flush_i.
	always @(posedge sys_clk) begin
		if (sys_rst)
			in_walk = 1'b0;
		else if (in_walk) begin
			if (busy_i) begin
				walk_len++;
				if (pipe_ack_i)
					walk_acks++;
			end else
				finish_walk();
		end else if (flush_i) begin
			in_walk = 1'b1;
			walk_len = 0;
			walk_acks = 0;
		end
	end

endmodule

/* tb_top.sv */
`timescale 1ns/1ns
// testbench top for the texel cache front end.
// replays tmu_tests.txt against the DUT with random fetch and
// fragment back-pressure, and reports the result.
`include "tmu_consts.svh"

module tb_top;

	localparam int MAX_STEPS = 64;
	localparam int CYCLES_PER_STEP = 64;

	logic sys_clk = 1'b0;
	logic sys_rst;
	logic flush_i, pipe_stb_i, fetch_ack_i, frag_ack_i;
	logic [`TMU_DADR_W-1:0] dadr_i;
	logic [`TMU_ADDR_W-1:0] tadra_i, tadrb_i, tadrc_i, tadrd_i;
	logic [`TMU_FRAC_W-1:0] x_frac_i, y_frac_i;
	logic busy_o, pipe_ack_o, fetch_stb_o, frag_stb_o;
	logic [`TMU_ADDR_W-1:0] fetch_adr_o;
	logic [`TMU_DADR_W-1:0] frag_dadr_o;
	logic [`TMU_ADDR_W-1:0] frag_tadra_o, frag_tadrb_o, frag_tadrc_o, frag_tadrd_o;
	logic [`TMU_FRAC_W-1:0] frag_x_frac_o, frag_y_frac_o;
	logic [3:0] frag_miss_o;
	int n_pass, n_fail, n_err, n_open;
	logic [31:0] lfsr = 32'hd089;

	// test steps as read from the file.
	logic is_flush [MAX_STEPS];
	string step_name [MAX_STEPS];
	logic [`TMU_DADR_W-1:0] step_dadr [MAX_STEPS];
	logic [`TMU_ADDR_W-1:0] step_tadr [MAX_STEPS][4];
	logic [`TMU_FRAC_W-1:0] step_xf [MAX_STEPS];
	logic [`TMU_FRAC_W-1:0] step_yf [MAX_STEPS];
	logic [3:0] step_miss [MAX_STEPS];
	logic [`TMU_ADDR_W-1:0] step_fetch [MAX_STEPS][4];
	int n_steps = 0;
	int n_frags = 0;
	int load_err = 0;
	bit loaded = 1'b0;

	always #20 sys_clk = ~sys_clk;

	tmu_texcache u_dut (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush_i),
		.busy_o(busy_o),
		.pipe_stb_i(pipe_stb_i),
		.pipe_ack_o(pipe_ack_o),
		.dadr_i(dadr_i),
		.tadra_i(tadra_i),
		.tadrb_i(tadrb_i),
		.tadrc_i(tadrc_i),
		.tadrd_i(tadrd_i),
		.x_frac_i(x_frac_i),
		.y_frac_i(y_frac_i),
		.fetch_stb_o(fetch_stb_o),
		.fetch_adr_o(fetch_adr_o),
		.fetch_ack_i(fetch_ack_i),
		.frag_stb_o(frag_stb_o),
		.frag_dadr_o(frag_dadr_o),
		.frag_tadra_o(frag_tadra_o),
		.frag_tadrb_o(frag_tadrb_o),
		.frag_tadrc_o(frag_tadrc_o),
		.frag_tadrd_o(frag_tadrd_o),
		.frag_x_frac_o(frag_x_frac_o),
		.frag_y_frac_o(frag_y_frac_o),
		.frag_miss_o(frag_miss_o),
		.frag_ack_i(frag_ack_i)
	);

	tb_checker u_chk (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush_i),
		.busy_i(busy_o),
		.pipe_ack_i(pipe_ack_o),
		.fetch_stb_i(fetch_stb_o),
		.fetch_ack_i(fetch_ack_i),
		.fetch_adr_i(fetch_adr_o),
		.frag_stb_i(frag_stb_o),
		.frag_ack_i(frag_ack_i),
		.frag_word_i({frag_dadr_o, frag_tadra_o, frag_tadrb_o, frag_tadrc_o,
			frag_tadrd_o, frag_x_frac_o, frag_y_frac_o}),
		.frag_miss_i(frag_miss_o),
		.n_pass_o(n_pass),
		.n_fail_o(n_fail),
		.n_err_o(n_err),
		.n_open_o(n_open)
	);

	// galois form, x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// ====================
	// test file
	// ====================
	task automatic load_tests();
		int fd, code;
		string word, name, rest;
		logic [`TMU_DADR_W-1:0] dadr;
		logic [`TMU_ADDR_W-1:0] ta, tb, tc, td, f0, f1, f2, f3;
		logic [`TMU_FRAC_W-1:0] xf, yf;
		logic [3:0] miss;
		fd = $fopen("tmu_tests.txt", "r");
		if (fd == 0) begin
			$display("error: cannot open tmu_tests.txt");
			load_err++;
		end else begin
			while (load_err == 0 && n_steps < MAX_STEPS && $fscanf(fd, "%s", word) == 1) begin
				if (word == "#") begin
					code = $fgets(rest, fd); // comment line.
				end else if (word == "flush") begin
					is_flush[n_steps] = 1'b1;
					n_steps++;
				end else if (word == "frag") begin
					code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
						name, dadr, ta, tb, tc, td, xf, yf, miss, f0, f1, f2, f3);
					if (code != 13) begin
						$display("error: malformed fragment line after step %0d", n_steps);
						load_err++;
					end
					is_flush[n_steps] = 1'b0;
					step_name[n_steps] = name;
					step_dadr[n_steps] = dadr;
					step_tadr[n_steps][0] = ta;
					step_tadr[n_steps][1] = tb;
					step_tadr[n_steps][2] = tc;
					step_tadr[n_steps][3] = td;
					step_xf[n_steps] = xf;
					step_yf[n_steps] = yf;
					step_miss[n_steps] = miss;
					step_fetch[n_steps][0] = f0;
					step_fetch[n_steps][1] = f1;
					step_fetch[n_steps][2] = f2;
					step_fetch[n_steps][3] = f3;
					n_steps++;
					n_frags++;
				end else begin
					$display("error: unknown step kind %s in tmu_tests.txt", word);
					load_err++;
				end
			end
			$fclose(fd);
		end
	endtask

	// ====================
	// stimulus
	// ====================
	task automatic send_fragment(input int i);
		u_chk.add_expectation(step_name[i],
			{step_dadr[i], step_tadr[i][0], step_tadr[i][1], step_tadr[i][2],
			step_tadr[i][3], step_xf[i], step_yf[i]},
			step_miss[i], step_fetch[i][0], step_fetch[i][1], step_fetch[i][2],
			step_fetch[i][3]);
		@(negedge sys_clk);
		pipe_stb_i = 1'b1;
		dadr_i = step_dadr[i];
		tadra_i = step_tadr[i][0];
		tadrb_i = step_tadr[i][1];
		tadrc_i = step_tadr[i][2];
		tadrd_i = step_tadr[i][3];
		x_frac_i = step_xf[i];
		y_frac_i = step_yf[i];
		do begin
			@(posedge sys_clk);
		end while (!pipe_ack_o);
	endtask

	task automatic run_flush();
		@(negedge sys_clk);
		pipe_stb_i = 1'b0;
		while (busy_o)
			@(negedge sys_clk); // tag stage must be empty.
		flush_i = 1'b1;
		do begin
			@(negedge sys_clk);
		end while (!busy_o);
		flush_i = 1'b0;
		while (busy_o)
			@(negedge sys_clk);
	endtask

	// sink back-pressure, one lfsr step per bit.
	always @(negedge sys_clk) begin
		fetch_ack_i = lfsr[0];
		lfsr = lfsr_step(lfsr);
		frag_ack_i = lfsr[0];
		lfsr = lfsr_step(lfsr);
	end

	initial begin
		sys_rst = 1'b1;
		flush_i = 1'b0;
		pipe_stb_i = 1'b0;
		fetch_ack_i = 1'b0;
		frag_ack_i = 1'b0;
		dadr_i = '0;
		tadra_i = '0;
		tadrb_i = '0;
		tadrc_i = '0;
		tadrd_i = '0;
		x_frac_i = '0;
		y_frac_i = '0;
		load_tests();
		loaded = 1'b1;
		repeat (16) @(negedge sys_clk);
		sys_rst = 1'b0;
		for (int i = 0; i < n_steps; i++) begin
			if (is_flush[i])
				run_flush();
			else
				send_fragment(i);
		end
		@(negedge sys_clk);
		pipe_stb_i = 1'b0;
		while (n_open != 0)
			@(negedge sys_clk);
		repeat (8) @(negedge sys_clk); // late or duplicated outputs.
		$display("tests: %0d passed, %0d failed, %0d failed checks", n_pass, n_fail, n_err);
		if (load_err == 0 && n_frags > 0 && n_err == 0 && n_fail == 0 && n_pass == n_steps)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// watchdog, sized by the number of steps.
	initial begin
		wait (loaded);
		repeat (32 + n_steps * CYCLES_PER_STEP) @(posedge sys_clk);
		$display("error: timeout, the run did not finish within %0d cycles",
			32 + n_steps * CYCLES_PER_STEP);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tmu_tests.txt */
# frag <name> <dadr> <tadr a> <tadr b> <tadr c> <tadr d> <x frac> <y frac> <miss dcba> <fetch 0..3>
# all hex; fetch columns beyond the number of misses are unused. flush clears all tags.
flush
frag all4_cold 0001 0203 0224 0440 047f 10 20 f 0200 0220 0440 0460
frag all4_hit 0002 0201 0230 0445 0460 10 20 0 0000 0000 0000 0000
frag xfrac_zero 0010 0682 06a0 06c8 06e0 00 15 5 0680 06c0 0000 0000
frag yfrac_zero 0011 0900 0927 0b40 0b60 21 00 3 0900 0920 0000 0000
frag only_a 0012 06a0 7e00 7e20 7e40 00 00 1 06a0 0000 0000 0000
frag one_line 0100 0d60 0d64 0d78 0d7f 01 01 8 0d60 0000 0000 0000
frag two_groups 0101 0f81 0fa2 0f9c 0fbe 3f 3f c 0f80 0fa0 0000 0000
frag index_clash 0102 11c0 13c0 0440 0460 08 08 2 13c0 0000 0000 0000
frag rehit 0200 0690 7fff 06d0 7fff 00 03 0 0000 0000 0000 0000
frag rehit_groups 0201 0d60 0f80 0fa0 13c0 2a 15 0 0000 0000 0000 0000
frag tag_replace 0300 2005 0000 0000 0000 00 00 1 2000 0000 0000 0000
frag old_tag_miss 0301 0203 0000 0000 0000 00 00 1 0200 0000 0000 0000
frag three_miss 1234 4021 4242 4463 447a 11 22 b 4020 4240 4460 0000
frag three_hit 1235 403f 425f 4470 4460 11 22 0 0000 0000 0000 0000
frag four_miss 7fff 6081 62a2 64c3 66e4 3f 01 f 6080 62a0 64c0 66e0
flush
frag after_flush 4000 0201 0230 0445 0460 05 06 f 0200 0220 0440 0460
frag refill_hit 4001 0201 0230 0445 0460 05 06 0 0000 0000 0000 0000

/* tb.f */
+incdir+.
tmu_addr_pkg.sv
tmu_ctl_pkg.sv
tmu_dpram.sv
tmu_tagmem.sv
tmu_miss_fetch.sv
tmu_texcache.sv
tb_checker.sv
tb_top.sv

/* Makefile */
# Verilator simulation of the texel cache front end.
TOP = tb_top

sim:
	verilator --binary --timing -Wno-fatal -f tb.f --top-module $(TOP) -o sim_$(TOP)
	out=$$(./obj_dir/sim_$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean
